/* Makefile */
TOP := tb_signal_router

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): files.f *.sv *.svh
	verilator --binary --timing --assert --top-module $(TOP) -f files.f

# pass only when the pass line shows up in the simulator output
run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

lint:
	verilator --lint-only --timing -Wall --top-module signal_router -f files.f

clean:
	rm -rf obj_dir

/* files.f */
+incdir+.
router_dims_pkg.sv
route_cfg_pkg.sv
frame_if.sv
route_table.sv
sample_capture.sv
output_crossbar.sv
signal_router.sv
tb_signal_router.sv

/* frame_if.sv */
`timescale 1ns/100ps

// one frame between the capture stage and the crossbar
// valid/ready handshake, transfer on valid && ready
interface frame_if import router_dims_pkg::*; ();

	in_frame_t	samples;	// captured input frame
	tag_t		tag;		// sequence tag of that frame
	logic		valid;		// frame waiting for the crossbar
	logic		ready;		// crossbar can take it this edge

	// capture side
	modport src (
		output	samples,
		output	tag,
		output	valid,
		input	ready
	);

	// crossbar side
	modport dst (
		input	samples,
		input	tag,
		input	valid,
		output	ready
	);

endinterface

/* output_crossbar.sv */
`timescale 1ns/100ps

// per-output source select with enable gating
// result registered together with the frame tag
module output_crossbar
	import router_dims_pkg::*;
	import route_cfg_pkg::*;
(
	input  logic		update_in,		// system clock
	input  logic		arst_n,			// async reset, active low

	frame_if.dst		fr,				// captured frames

	input  route_map_t	route_map,		// table from route_table

	// output frames
	output logic		out_valid,		// out_data and out_tag hold a frame
	input  logic		out_ready,		// sink takes it this edge
	output out_frame_t	out_data,		// eight routed samples
	output tag_t		out_tag			// tag of that frame
);

	out_frame_t	xbar_data;		// routed frame before the register
	logic		fr_take;		// frame_if transfer this edge

	////////////////////////////////////////////////////////////
	// handshake
	////////////////////////////////////////////////////////////

	// room when empty or when the held frame leaves now
	assign fr.ready = !out_valid || out_ready;
	assign fr_take  = fr.valid && fr.ready;

	////////////////////////////////////////////////////////////
	// source mux, one per output
	////////////////////////////////////////////////////////////

	for (genvar o = 0; o < n_out; o++) begin : g_mux
		route_entry_t	ent;		// entry for this output

		assign ent = route_map[o];

		// disabled entry drives zero, whatever src holds
		assign xbar_data[o] = ent.enable ? fr.samples[ent.src] : sample_t'(0);
	end

	////////////////////////////////////////////////////////////
	// output register
	////////////////////////////////////////////////////////////

	always_ff @(posedge update_in or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
		end else if (fr_take) begin
			out_valid <= 1'b1;				// new frame replaces or fills
		end else if (out_ready) begin
			out_valid <= 1'b0;				// sink drained it
		end
	end

	// table is sampled on the same edge the frame enters
	always_ff @(posedge update_in) begin
		if (fr_take) begin
			out_data <= xbar_data;
			out_tag  <= fr.tag;
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	// sink back-pressure freezes the output
	a_out_hold: assert property (
		@(posedge update_in) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_tag)
	);

endmodule

/* route_cfg_pkg.sv */
package route_cfg_pkg;

	import router_dims_pkg::*;	// channel counts and index width

	////////////////////////////////////////////////////////////
	// routing table types
	////////////////////////////////////////////////////////////

	// channel number, input or output side
	typedef logic [w_sel-1:0] chan_sel_t;

	// one table entry per output channel
	typedef struct packed {
		chan_sel_t	src;		// input channel to copy
		logic		enable;		// low forces the output to zero
	} route_entry_t;

	// the whole table, entry 0 in the low bits
	typedef route_entry_t [n_out-1:0] route_map_t;

	// reset value of every entry
	// disabled, so nothing pulls from input 0 before it is set up
	localparam route_entry_t entry_off = '{src: '0, enable: 1'b0};

endpackage

/* route_table.sv */
`timescale 1ns/100ps

// per-output routing table
// written one entry per accepted command
module route_table
	import router_dims_pkg::*;
	import route_cfg_pkg::*;
(
	input  logic		update_in,		// system clock
	input  logic		arst_n,			// async reset, active low

	// configuration port
	input  logic		cfg_valid,		// command present
	output logic		cfg_ready,		// table can take a command
	input  chan_sel_t	cfg_dest,		// output channel to write
	input  chan_sel_t	cfg_src,		// input channel it copies
	input  logic		cfg_enable,		// output on or forced zero

	// to the crossbar
	output route_map_t	route_map		// current table
);

	////////////////////////////////////////////////////////////
	// internal state
	////////////////////////////////////////////////////////////

	route_map_t	map_q;					// one entry per output
	logic		cfg_take;				// command accepted this edge
	route_entry_t	cfg_entry;			// entry built from the command

	assign cfg_take  = cfg_valid && cfg_ready;
	assign cfg_entry = '{src: cfg_src, enable: cfg_enable};

	////////////////////////////////////////////////////////////
	// table and ready flag
	////////////////////////////////////////////////////////////

	always_ff @(posedge update_in or negedge arst_n) begin
		if (!arst_n) begin
			cfg_ready <= 1'b0;					// low through reset
			for (int i = 0; i < n_out; i++) begin
				map_q[i] <= entry_off;			// every output starts silent
			end
		end else begin
			cfg_ready <= 1'b1;					// always ready once running
			if (cfg_take) begin
				map_q[cfg_dest] <= cfg_entry;	// visible from next cycle
			end
		end
	end

	assign route_map = map_q;

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	// the port must be driven once out of reset
	a_cfg_valid_known: assert property (
		@(posedge update_in) disable iff (!arst_n)
		!$isunknown(cfg_valid)
	);

endmodule

/* router_dims_pkg.sv */
package router_dims_pkg;

	////////////////////////////////////////////////////////////
	// channel counts and widths
	////////////////////////////////////////////////////////////

	localparam int unsigned w_chan	= 16;				// bits per sample
	localparam int unsigned n_in	= 8;				// input channels per frame
	localparam int unsigned n_out	= 8;				// output channels per frame
	localparam int unsigned w_sel	= $clog2(n_in);		// channel index, 3 bits
	localparam int unsigned w_tag	= 8;				// frame sequence tag, wraps at 256

	////////////////////////////////////////////////////////////
	// data path types
	////////////////////////////////////////////////////////////

	// one signed sample as produced by the controller core
	typedef logic signed [w_chan-1:0] sample_t;

	// whole input frame on a single bus
	// channel 0 sits in the low 16 bits
	typedef sample_t [n_in-1:0] in_frame_t;

	// whole output frame, same packing as the input
	typedef sample_t [n_out-1:0] out_frame_t;

	// frame sequence tag
	// counts accepted input frames
	typedef logic [w_tag-1:0] tag_t;

endpackage

/* sample_capture.sv */
`timescale 1ns/100ps

// one-entry capture register in front of the crossbar
// full throughput, tags each accepted frame
module sample_capture
	import router_dims_pkg::*;
(
	input  logic		update_in,		// system clock
	input  logic		arst_n,			// async reset, active low

	// input frames from the core
	input  logic		in_valid,		// frame on in_data
	output logic		in_ready,		// stage can take it
	input  in_frame_t	in_data,		// eight packed samples

	frame_if.src		fr				// toward the crossbar
);

	logic	run_q;			// set one edge after reset release
	tag_t	tag_cnt;		// tag for the next accepted frame
	logic	in_take;		// input handshake this edge

	// free slot, or the held frame leaves on this same edge
	assign in_ready = run_q && (!fr.valid || fr.ready);
	assign in_take  = in_valid && in_ready;

	////////////////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////////////////

	always_ff @(posedge update_in or negedge arst_n) begin
		if (!arst_n) begin
			run_q   <= 1'b0;
			fr.valid <= 1'b0;
			tag_cnt <= '0;						// first frame gets tag 0
		end else begin
			run_q <= 1'b1;
			if (in_take) begin
				fr.valid <= 1'b1;
				tag_cnt  <= tag_cnt + 1'b1;		// wraps at 256
			end else if (fr.ready) begin
				fr.valid <= 1'b0;				// slot drained
			end
		end
	end

	// payload, loaded only on accept so it holds through a stall
	always_ff @(posedge update_in) begin
		if (in_take) begin
			fr.samples <= in_data;
			fr.tag     <= tag_cnt;
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	// a stalled frame stays put until the crossbar takes it
	a_hold_stalled: assert property (
		@(posedge update_in) disable iff (!arst_n)
		fr.valid && !fr.ready |=> fr.valid && $stable(fr.samples) && $stable(fr.tag)
	);

endmodule

/* signal_router.sv */
`timescale 1ns/100ps

// sample router top
// table and capture side by side, crossbar behind them
module signal_router
	import router_dims_pkg::*;
	import route_cfg_pkg::*;
(
	input  logic		update_in,		// system clock
	input  logic		arst_n,			// async reset, active low

	// configuration port, front panel
	input  logic		cfg_valid,		// table write request
	output logic		cfg_ready,		// table accepts writes
	input  chan_sel_t	cfg_dest,		// output channel to set
	input  chan_sel_t	cfg_src,		// input channel to copy
	input  logic		cfg_enable,		// output on or zero

	// input frames
	input  logic		in_valid,
	output logic		in_ready,
	input  in_frame_t	in_data,		// eight signed samples

	// output frames
	output logic		out_valid,
	input  logic		out_ready,
	output out_frame_t	out_data,		// eight routed samples
	output tag_t		out_tag			// input frame sequence number
);

	route_map_t	route_map;		// table to crossbar
	frame_if	cap_fr ();		// capture to crossbar

	////////////////////////////////////////////////////////////
	// routing table
	////////////////////////////////////////////////////////////

	route_table table_i (
		.update_in	(update_in),
		.arst_n		(arst_n),
		.cfg_valid	(cfg_valid),
		.cfg_ready	(cfg_ready),
		.cfg_dest	(cfg_dest),
		.cfg_src	(cfg_src),
		.cfg_enable	(cfg_enable),
		.route_map	(route_map)
	);

	////////////////////////////////////////////////////////////
	// data path
	////////////////////////////////////////////////////////////

	sample_capture capture_i (
		.update_in	(update_in),
		.arst_n		(arst_n),
		.in_valid	(in_valid),
		.in_ready	(in_ready),
		.in_data	(in_data),
		.fr			(cap_fr.src)
	);

	output_crossbar xbar_i (
		.update_in	(update_in),
		.arst_n		(arst_n),
		.fr			(cap_fr.dst),
		.route_map	(route_map),
		.out_valid	(out_valid),
		.out_ready	(out_ready),
		.out_data	(out_data),
		.out_tag	(out_tag)
	);

endmodule

/* tb_route_model.svh */
`ifndef TB_ROUTE_MODEL_SVH
`define TB_ROUTE_MODEL_SVH

////////////////////////////////////////////////////////////
// reference model
////////////////////////////////////////////////////////////

// expected output frame for one input frame and one table
// disabled output gives zero, enabled output copies its source
function automatic out_frame_t route_frame(input in_frame_t din, input route_map_t rmap);
	logic [n_in*w_chan-1:0]		flat_in;		// input frame as plain bits
	logic [n_out*w_chan-1:0]	flat_out;		// built up one lane at a time
	int							src;			// source lane number
	flat_in  = din;
	flat_out = '0;								// every lane silent unless enabled
	for (int o = 0; o < n_out; o++) begin
		if (rmap[o].enable) begin
			src = int'(rmap[o].src);
			flat_out[o*w_chan +: w_chan] = flat_in[src*w_chan +: w_chan];	// lane copy
		end
	end
	return flat_out;
endfunction

////////////////////////////////////////////////////////////
// compare
////////////////////////////////////////////////////////////

// narrow values are zero extended by the caller
task automatic check_equal(
	input logic [127:0]	got,		// value seen on the DUT
	input logic [127:0]	exp,		// value from the model
	input string		what		// what was compared
);
	if (got !== exp) begin
		$display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
			$time, what, got, exp);
		$display("TEST FAIL");
		$fatal(1, "stopped at first mismatch");
	end
endtask

`endif

/* tb_signal_router.sv */
`timescale 1ns/100ps

module tb_signal_router
	import router_dims_pkg::*;
	import route_cfg_pkg::*;
();

	localparam int n_ph1       = 20;			// frames before any table write
	localparam int n_ph2       = 20 + n_out + 12;	// identity, then permutation
	localparam int n_ph3       = 20;			// fan-out, then one entry off
	localparam int n_ph4       = 60;			// back-pressure and gaps
	localparam int n_frames    = n_ph1 + n_ph2 + n_ph3 + n_ph4;
	localparam int n_cfg       = 3 * n_out + 1;	// table writes over the run
	localparam int timeout_lim = 4 * (n_frames + n_cfg) + 200;
	localparam int drive_dly   = 2;				// ns after the rising edge

	// one expected output frame
	typedef struct packed {
		out_frame_t	data;		// routed samples
		tag_t		tag;		// sequence number
		int			acc_cycle;	// cycle of the input handshake
		logic		timed;		// latency is checked for this one
	} exp_item_t;

	logic		update_in;
	logic		arst_n;
	logic		cfg_valid;
	logic		cfg_ready;
	chan_sel_t	cfg_dest;
	chan_sel_t	cfg_src;
	logic		cfg_enable;
	logic		in_valid;
	logic		in_ready;
	in_frame_t	in_data;
	logic		out_valid;
	logic		out_ready;
	out_frame_t	out_data;
	tag_t		out_tag;

	route_map_t	model_map;			// mirror of the accepted writes
	exp_item_t	exp_q[$];			// frames sent, not yet seen
	tag_t		exp_tag;			// tag of the next accepted frame
	int			cycles = 0;
	int			n_sent;
	int			n_recv;
	logic		bp_on;				// random out_ready when set
	logic		lat_chk;			// stamp new frames as timed

	`include "tb_route_model.svh"

	signal_router dut_i (
		.update_in	(update_in),
		.arst_n		(arst_n),
		.cfg_valid	(cfg_valid),
		.cfg_ready	(cfg_ready),
		.cfg_dest	(cfg_dest),
		.cfg_src	(cfg_src),
		.cfg_enable	(cfg_enable),
		.in_valid	(in_valid),
		.in_ready	(in_ready),
		.in_data	(in_data),
		.out_valid	(out_valid),
		.out_ready	(out_ready),
		.out_data	(out_data),
		.out_tag	(out_tag)
	);

	////////////////////////////////////////////////////////////
	// clock, cycle count, timeout
	////////////////////////////////////////////////////////////

	initial begin
		update_in = 1'b0;
		forever #20 update_in = ~update_in;		// 40 ns period
	end

	always @(posedge update_in) cycles <= cycles + 1;

	initial begin : watchdog
		while (cycles < timeout_lim) @(posedge update_in);
		$display("timeout: the run did not finish within %0d cycles", timeout_lim);
		$display("TEST FAIL");
		$fatal(1, "timeout");
	end

	////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////

	function automatic in_frame_t random_frame();
		in_frame_t f;
		for (int i = 0; i < n_in; i++) f[i] = sample_t'($urandom);
		return f;
	endfunction

	// hold the frame until in_ready is seen on an edge
	task automatic send_frame(input in_frame_t data);
		in_valid = 1'b1;
		in_data  = data;
		do @(posedge update_in); while (!in_ready);
		#(drive_dly);
		in_valid = 1'b0;
	endtask

	task automatic write_entry(input chan_sel_t dest, input chan_sel_t src, input logic en);
		cfg_valid  = 1'b1;
		cfg_dest   = dest;
		cfg_src    = src;
		cfg_enable = en;
		do @(posedge update_in); while (!cfg_ready);
		model_map[dest] = '{src: src, enable: en};	// mirror the accepted write
		#(drive_dly);
		cfg_valid = 1'b0;
	endtask

	// nothing in flight once every sent frame came back
	task automatic wait_idle();
		while (n_sent != n_recv) begin
			@(posedge update_in);
			#(drive_dly);
		end
	endtask

	////////////////////////////////////////////////////////////
	// sink and monitors
	////////////////////////////////////////////////////////////

	initial begin : sink
		forever begin
			@(posedge update_in);
			#(drive_dly);
			out_ready = bp_on ? ($urandom % 4 != 0) : 1'b1;		// stall about 1 in 4
		end
	end

	initial begin : input_monitor
		forever begin
			@(posedge update_in);
			if (arst_n && in_valid && in_ready) begin
				exp_q.push_back('{data: route_frame(in_data, model_map), tag: exp_tag,
					acc_cycle: cycles, timed: lat_chk});
				exp_tag = exp_tag + 1'b1;		// wraps like the DUT counter
				n_sent++;
			end
		end
	end

	initial begin : compare_out
		exp_item_t	item;
		logic		held;		// stalled frame on the last edge
		out_frame_t	held_data;
		tag_t		held_tag;
		held      = 1'b0;
		held_data = '0;
		held_tag  = '0;
		forever begin
			@(posedge update_in);
			if (arst_n) begin
				if (held) begin
					check_equal(128'(out_valid), 128'(1), "out_valid dropped during stall");
					check_equal(out_data, held_data, "out_data moved during stall");
					check_equal(128'(out_tag), 128'(held_tag), "out_tag moved during stall");
				end
				if (out_valid && out_ready) begin
					check_equal(128'(exp_q.size() != 0), 128'(1), "frame with none outstanding");
					item = exp_q.pop_front();
					check_equal(out_data, item.data, "routed data");
					check_equal(128'(out_tag), 128'(item.tag), "frame tag");
					if (item.timed) begin
						check_equal(128'(cycles - item.acc_cycle), 128'(2), "in to out latency");
					end
					n_recv++;
				end
				held      = out_valid && !out_ready;
				held_data = out_data;
				held_tag  = out_tag;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin : stim
		chan_sel_t	perm [n_out];		// random permutation map
		chan_sel_t	tmp;
		chan_sel_t	fan_src;			// single source for fan-out
		int			j;
		void'($urandom(32'hdfc07249));
		arst_n     = 1'b0;
		cfg_valid  = 1'b0;
		cfg_dest   = '0;
		cfg_src    = '0;
		cfg_enable = 1'b0;
		in_valid   = 1'b0;
		in_data    = '0;
		out_ready  = 1'b1;
		bp_on      = 1'b0;
		lat_chk    = 1'b1;			// timed until back-pressure starts
		exp_tag    = '0;
		n_sent     = 0;
		n_recv     = 0;
		model_map  = '0;			// all entries disabled
		repeat (8) @(posedge update_in);
		#(drive_dly);
		check_equal(128'(cfg_ready), 128'(0), "cfg_ready during reset");
		check_equal(128'(in_ready), 128'(0), "in_ready during reset");
		check_equal(128'(out_valid), 128'(0), "out_valid during reset");
		repeat (8) @(posedge update_in);
		#(drive_dly);
		arst_n = 1'b1;
		repeat (2) @(posedge update_in);
		#(drive_dly);
		check_equal(128'(cfg_ready), 128'(1), "cfg_ready after reset");

		// unconfigured table, all outputs zero
		for (int i = 0; i < n_ph1; i++) send_frame(random_frame());
		wait_idle();

		// identity map
		for (int d = 0; d < n_out; d++) write_entry(chan_sel_t'(d), chan_sel_t'(d), 1'b1);
		for (int i = 0; i < 20; i++) send_frame(random_frame());
		wait_idle();

		// shuffle
		for (int i = 0; i < n_out; i++) perm[i] = chan_sel_t'(i);
		for (int i = n_out - 1; i > 0; i--) begin
			j       = int'($urandom % (i + 1));
			tmp     = perm[i];
			perm[i] = perm[j];
			perm[j] = tmp;
		end
		for (int d = 0; d < n_out; d++) begin
			write_entry(chan_sel_t'(d), perm[d], 1'b1);
			send_frame(random_frame());		// shows this one write alone
			wait_idle();
		end
		for (int i = 0; i < 12; i++) send_frame(random_frame());
		wait_idle();

		// fan-out from one input, then one output switched off
		fan_src = chan_sel_t'($urandom);
		for (int d = 0; d < n_out; d++) write_entry(chan_sel_t'(d), fan_src, 1'b1);
		for (int i = 0; i < 10; i++) send_frame(random_frame());
		wait_idle();
		write_entry(chan_sel_t'($urandom), fan_src, 1'b0);
		for (int i = 0; i < 10; i++) send_frame(random_frame());
		wait_idle();

		// random stalls on both sides
		bp_on   = 1'b1;
		lat_chk = 1'b0;
		for (int i = 0; i < n_ph4; i++) begin
			send_frame(random_frame());
			repeat ($urandom % 4) begin
				@(posedge update_in);
				#(drive_dly);
			end
		end
		wait_idle();

		if (exp_q.size() == 0 && n_sent == n_frames) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("run ended with %0d of %0d frames sent and %0d still expected",
				n_sent, n_frames, exp_q.size());
			$display("TEST FAIL");
			$fatal(1, "frames missing at end of run");
		end
	end

endmodule
